// File: Makefile
TOP := lsu_tb

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f flist.f

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

// File: flist.f
+incdir+logic
logic/lsu_pkg.sv
logic/lsu_job_if.sv
logic/lsu_op_accept.sv
logic/lsu_mem_req.sv
logic/lsu_load_wb.sv
logic/lsu_top.sv
verif/lsu_asserts.sv
verif/lsu_tb.sv

// File: logic/lsu_cfg.svh
//////////////////////////////////////////////////
// build-time widths of the vector load/store unit
// included by the package and by the RTL modules
//////////////////////////////////////////////////
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// one vector register
`define LSU_VREG_W 128
// memory data port, four beats per register
`define LSU_VMEM_W 32
`define LSU_ADDR_W 32
// vl counts elements, 0 to 16
`define LSU_VL_W 5

`endif

// File: logic/lsu_job_if.sv
//////////////////////////////////////////////////
// accepted job, passed from the acceptor to the
// request stage and the load write-back stage
//////////////////////////////////////////////////
`timescale 1ns/100ps

interface lsu_job_if;
    import lsu_pkg::*;

    // one-cycle pulse, fields below stay put until the done pulses
    logic      start;
    logic      store;
    addr_t     base;
    vaddr_t    vd;
    vl_bytes_t vl_bytes;
    vreg_t     wdata;
    logic      req_done;
    logic      wb_done;

    modport accept_mp (
        output start, store, base, vd, vl_bytes, wdata,
        input  req_done, wb_done
    );

    modport req_mp (
        input  start, store, base, vl_bytes, wdata,
        output req_done
    );

    modport wb_mp (
        input  start, store, vd, vl_bytes,
        output wb_done
    );

endinterface

// File: logic/lsu_load_wb.sv
//////////////////////////////////////////////////
// load write-back stage, collects the returned beats
// and writes them to vd in one masked write
//////////////////////////////////////////////////
`timescale 1ns/100ps
`include "lsu_cfg.svh"

module lsu_load_wb (
    input  logic            clk_i,
    input  logic            async_rst_ni,
    lsu_job_if.wb_mp        job,
    input  logic            data_rvalid_i,
    input  lsu_pkg::vmem_t  data_rdata_i,
    output logic            vreg_wr_en_o,
    output lsu_pkg::vaddr_t vreg_wr_addr_o,
    output lsu_pkg::vreg_t  vreg_wr_data_o,
    output lsu_pkg::vmsk_t  vreg_wr_mask_o
);
    import lsu_pkg::*;

    logic  active_q;
    logic  wr_q;
    logic  take;
    beat_t cnt_q;
    vreg_t shift_q;

    // read data arrives in request order, one beat per rvalid
    assign take = active_q & data_rvalid_i;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            active_q <= 1'b0;
            cnt_q    <= '0;
            wr_q     <= 1'b0;
        end else begin
            wr_q <= take & (cnt_q == '1);
            if (job.start & ~job.store) begin
                active_q <= 1'b1;
                cnt_q    <= '0;
            end else if (take) begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == '1) begin
                    active_q <= 1'b0;
                end
            end
        end
    end

    // fill from the top, beat 0 ends up in the low bytes
    always_ff @(posedge clk_i) begin
        if (take) begin
            shift_q <= {data_rdata_i, shift_q[`LSU_VREG_W-1:`LSU_VMEM_W]};
        end
    end

    //////////////////////////////////////////////////
    // register write
    //////////////////////////////////////////////////

    assign job.wb_done     = wr_q;
    assign vreg_wr_en_o    = wr_q;
    assign vreg_wr_addr_o  = job.vd;
    assign vreg_wr_data_o  = shift_q;
    assign vreg_wr_mask_o  = vl_mask(job.vl_bytes);

endmodule

// File: logic/lsu_mem_req.sv
//////////////////////////////////////////////////
// memory request stage, issues the four beats of a
// job over the req/gnt handshake
//////////////////////////////////////////////////
`timescale 1ns/100ps
`include "lsu_cfg.svh"

module lsu_mem_req (
    input  logic           clk_i,
    input  logic           async_rst_ni,
    lsu_job_if.req_mp      job,
    output logic           data_req_o,
    output logic           data_we_o,
    output lsu_pkg::addr_t data_addr_o,
    output lsu_pkg::be_t   data_be_o,
    output lsu_pkg::vmem_t data_wdata_o,
    input  logic           data_gnt_i
);
    import lsu_pkg::*;

    localparam int unsigned BEAT_BYTES = `LSU_VMEM_W / 8;

    logic  active_q;
    logic  grant;
    logic  last_beat;
    beat_t beat_q;
    addr_t addr_q;
    vmsk_t vl_msk;

    assign grant     = active_q & data_gnt_i;
    assign last_beat = (beat_q == '1);

    //////////////////////////////////////////////////
    // beat counter and address
    //////////////////////////////////////////////////

    // a missing grant holds everything, so the request stays stable
    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            active_q <= 1'b0;
            beat_q   <= '0;
        end else begin
            if (job.start) begin
                active_q <= 1'b1;
                beat_q   <= '0;
            end else if (grant) begin
                beat_q <= beat_q + 1'b1;
                if (last_beat) begin
                    active_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (job.start) begin
            addr_q <= job.base;
        end else if (grant) begin
            addr_q <= addr_q + addr_t'(BEAT_BYTES);
        end
    end

    assign job.req_done = grant & last_beat;

    //////////////////////////////////////////////////
    // request fields
    //////////////////////////////////////////////////

    assign data_req_o  = active_q;
    assign data_we_o   = active_q & job.store;
    assign data_addr_o = addr_q;

    // beat k carries register bytes 4k to 4k+3
    assign data_wdata_o = job.wdata[beat_q*`LSU_VMEM_W +: `LSU_VMEM_W];

    // loads read the whole word, stores write only bytes below vl
    assign vl_msk    = vl_mask(job.vl_bytes);
    assign data_be_o = job.store ? vl_msk[beat_q*BEAT_BYTES +: BEAT_BYTES] : '1;

endmodule

// File: logic/lsu_op_accept.sv
//////////////////////////////////////////////////
// operation acceptor, latches one job at a time and
// keeps the busy flags behind op_ready and pending
//////////////////////////////////////////////////
`timescale 1ns/100ps
`include "lsu_cfg.svh"

module lsu_op_accept (
    input  logic            clk_i,
    input  logic            async_rst_ni,
    input  logic            op_valid_i,
    input  logic            op_store_i,
    input  lsu_pkg::eew_e   op_eew_i,
    input  lsu_pkg::vl_t    op_vl_i,
    input  lsu_pkg::addr_t  op_base_i,
    input  lsu_pkg::vaddr_t op_vd_i,
    input  lsu_pkg::vreg_t  vreg_rd_data_i,
    output logic            op_ready_o,
    output logic            misaligned_o,
    output lsu_pkg::vaddr_t vreg_rd_addr_o,
    output logic            pending_load_o,
    output logic            pending_store_o,
    lsu_job_if.accept_mp    job
);
    import lsu_pkg::*;

    // byte offset bits within one memory word
    localparam int unsigned OFFS_W = $clog2(`LSU_VMEM_W / 8);

    logic                 accept;
    logic                 start_q;
    logic                 store_q;
    logic                 req_busy_q;
    logic                 wb_busy_q;
    logic [`LSU_VL_W+1:0] vl_prod;
    vl_bytes_t            vl_bytes_d;
    addr_t                base_q;
    vaddr_t               vd_q;
    vl_bytes_t            vl_bytes_q;
    vreg_t                wdata_q;

    assign op_ready_o     = ~req_busy_q & ~wb_busy_q;
    assign accept         = op_valid_i & op_ready_o;
    assign misaligned_o   = accept & (op_base_i[OFFS_W-1:0] != '0);
    // store data comes straight from vd
    assign vreg_rd_addr_o = op_vd_i;

    // elements to bytes, at most one register
    always_comb begin
        unique case (op_eew_i)
            EEW_8:   vl_prod = {2'b00, op_vl_i};
            EEW_16:  vl_prod = {1'b0, op_vl_i, 1'b0};
            EEW_32:  vl_prod = {op_vl_i, 2'b00};
            default: vl_prod = '0;
        endcase
        vl_bytes_d = (vl_prod > 16) ? vl_bytes_t'(16) : vl_bytes_t'(vl_prod);
    end

    //////////////////////////////////////////////////
    // busy tracking
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            start_q    <= 1'b0;
            store_q    <= 1'b0;
            req_busy_q <= 1'b0;
            wb_busy_q  <= 1'b0;
        end else begin
            start_q <= accept;
            if (accept) begin
                store_q    <= op_store_i;
                req_busy_q <= 1'b1;
                // stores finish with their last grant
                wb_busy_q  <= ~op_store_i;
            end else begin
                if (job.req_done) begin
                    req_busy_q <= 1'b0;
                end
                if (job.wb_done) begin
                    wb_busy_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            base_q     <= op_base_i & ~addr_t'((1 << OFFS_W) - 1);
            vd_q       <= op_vd_i;
            vl_bytes_q <= vl_bytes_d;
            wdata_q    <= vreg_rd_data_i;
        end
    end

    assign pending_load_o  = wb_busy_q | (req_busy_q & ~store_q);
    assign pending_store_o = req_busy_q & store_q;

    assign job.start    = start_q;
    assign job.store    = store_q;
    assign job.base     = base_q;
    assign job.vd       = vd_q;
    assign job.vl_bytes = vl_bytes_q;
    assign job.wdata    = wdata_q;

endmodule

// File: logic/lsu_pkg.sv
//////////////////////////////////////////////////
// shared types of the vector load/store unit
//////////////////////////////////////////////////
`include "lsu_cfg.svh"

package lsu_pkg;

    typedef logic [`LSU_VREG_W-1:0]   vreg_t;
    typedef logic [`LSU_VREG_W/8-1:0] vmsk_t;
    typedef logic [`LSU_VMEM_W-1:0]   vmem_t;
    typedef logic [`LSU_VMEM_W/8-1:0] be_t;
    typedef logic [`LSU_ADDR_W-1:0]   addr_t;
    typedef logic [4:0]               vaddr_t;
    typedef logic [`LSU_VL_W-1:0]     vl_t;
    // active byte count, 0 to 16
    typedef logic [4:0]               vl_bytes_t;
    typedef logic [1:0]               beat_t;

    typedef enum logic [1:0] {
        EEW_8  = 2'b00,
        EEW_16 = 2'b01,
        EEW_32 = 2'b10
    } eew_e;

    // register byte i is active when i < vl_bytes
    function automatic vmsk_t vl_mask(vl_bytes_t vl_bytes);
        vmsk_t msk;
        for (int i = 0; i < $bits(vmsk_t); i++) begin
            msk[i] = (i < vl_bytes);
        end
        return msk;
    endfunction

endpackage

// File: logic/lsu_top.sv
//////////////////////////////////////////////////
// vector load/store unit top level, unit-stride
// access of one 128-bit register over a 32-bit port
//////////////////////////////////////////////////
`timescale 1ns/100ps

module lsu_top (
    input  logic            clk_i,
    input  logic            async_rst_ni,

    // operation port
    input  logic            op_valid_i,
    input  logic            op_store_i,
    input  lsu_pkg::eew_e   op_eew_i,
    input  lsu_pkg::vl_t    op_vl_i,
    input  lsu_pkg::addr_t  op_base_i,
    input  lsu_pkg::vaddr_t op_vd_i,
    output logic            op_ready_o,
    output logic            misaligned_o,

    // register file
    output lsu_pkg::vaddr_t vreg_rd_addr_o,
    input  lsu_pkg::vreg_t  vreg_rd_data_i,
    output logic            vreg_wr_en_o,
    output lsu_pkg::vaddr_t vreg_wr_addr_o,
    output lsu_pkg::vreg_t  vreg_wr_data_o,
    output lsu_pkg::vmsk_t  vreg_wr_mask_o,

    // memory
    output logic            data_req_o,
    output lsu_pkg::addr_t  data_addr_o,
    output logic            data_we_o,
    output lsu_pkg::be_t    data_be_o,
    output lsu_pkg::vmem_t  data_wdata_o,
    input  logic            data_gnt_i,
    input  logic            data_rvalid_i,
    input  lsu_pkg::vmem_t  data_rdata_i,

    // status
    output logic            pending_load_o,
    output logic            pending_store_o
);

    lsu_job_if i_job ();

    lsu_op_accept i_op_accept (
        .clk_i           (clk_i),
        .async_rst_ni    (async_rst_ni),
        .op_valid_i      (op_valid_i),
        .op_store_i      (op_store_i),
        .op_eew_i        (op_eew_i),
        .op_vl_i         (op_vl_i),
        .op_base_i       (op_base_i),
        .op_vd_i         (op_vd_i),
        .vreg_rd_data_i  (vreg_rd_data_i),
        .op_ready_o      (op_ready_o),
        .misaligned_o    (misaligned_o),
        .vreg_rd_addr_o  (vreg_rd_addr_o),
        .pending_load_o  (pending_load_o),
        .pending_store_o (pending_store_o),
        .job             (i_job.accept_mp)
    );

    lsu_mem_req i_mem_req (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .job          (i_job.req_mp),
        .data_req_o   (data_req_o),
        .data_we_o    (data_we_o),
        .data_addr_o  (data_addr_o),
        .data_be_o    (data_be_o),
        .data_wdata_o (data_wdata_o),
        .data_gnt_i   (data_gnt_i)
    );

    lsu_load_wb i_load_wb (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .job            (i_job.wb_mp),
        .data_rvalid_i  (data_rvalid_i),
        .data_rdata_i   (data_rdata_i),
        .vreg_wr_en_o   (vreg_wr_en_o),
        .vreg_wr_addr_o (vreg_wr_addr_o),
        .vreg_wr_data_o (vreg_wr_data_o),
        .vreg_wr_mask_o (vreg_wr_mask_o)
    );

endmodule

// File: verif/lsu_asserts.sv
//////////////////////////////////////////////////
// protocol assertions on the load/store unit ports,
// bound into lsu_top
//////////////////////////////////////////////////
`timescale 1ns/100ps

module lsu_asserts (
    input logic           clk_i,
    input logic           async_rst_ni,
    input logic           req_i,
    input logic           gnt_i,
    input logic           we_i,
    input lsu_pkg::addr_t addr_i,
    input lsu_pkg::be_t   be_i,
    input lsu_pkg::vmem_t wdata_i,
    input logic           wr_en_i,
    input logic           valid_i,
    input logic           ready_i,
    input logic           pend_load_i,
    input logic           pend_store_i
);

    // an ungranted request holds all of its fields
    req_stable_a: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        req_i && !gnt_i |=> req_i && $stable({we_i, addr_i, be_i, wdata_i}))
        else $error("memory request changed before its grant");

    store_no_write_a: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        wr_en_i |-> !pend_store_i)
        else $error("register write pulse during a store");

    // an accepted operation drops op_ready_o and shows as pending
    accept_busy_a: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        valid_i && ready_i |=> !ready_i && (pend_load_i || pend_store_i))
        else $error("accepted operation did not drop op_ready_o and raise pending");

endmodule

bind lsu_top lsu_asserts i_lsu_asserts (
    .clk_i        (clk_i),
    .async_rst_ni (async_rst_ni),
    .req_i        (data_req_o),
    .gnt_i        (data_gnt_i),
    .we_i         (data_we_o),
    .addr_i       (data_addr_o),
    .be_i         (data_be_o),
    .wdata_i      (data_wdata_o),
    .wr_en_i      (vreg_wr_en_o),
    .valid_i      (op_valid_i),
    .ready_i      (op_ready_o),
    .pend_load_i  (pending_load_o),
    .pend_store_i (pending_store_o)
);

// File: verif/lsu_tb.sv
//////////////////////////////////////////////////
// testbench for the vector load/store unit, with a
// random-latency memory model and a reference check
//////////////////////////////////////////////////
`timescale 1ns/100ps

module lsu_tb;
    import lsu_pkg::*;

    // 40 operations of at most about 50 cycles each
    localparam int MAX_CYCLES = 2000;

    logic   clk_i, async_rst_ni, op_valid_i, op_store_i, op_ready_o, misaligned_o;
    eew_e   op_eew_i;
    vl_t    op_vl_i;
    addr_t  op_base_i, data_addr_o;
    vaddr_t op_vd_i, vreg_rd_addr_o, vreg_wr_addr_o;
    vreg_t  vreg_rd_data_i, vreg_wr_data_o;
    vmsk_t  vreg_wr_mask_o;
    logic   vreg_wr_en_o, data_req_o, data_we_o, pending_load_o, pending_store_o;
    be_t    data_be_o;
    vmem_t  data_wdata_o;
    logic   data_gnt_i = 1'b0;
    logic   data_rvalid_i = 1'b0;
    vmem_t  data_rdata_i = '0;

    integer seed = 90;
    int     cycles = 0;
    int     last_due = 0;
    int     beat_seen, wr_seen;
    logic [7:0] mem [0:1023];
    vreg_t  rf [0:31];
    vmem_t  rdata_q [$];
    int     due_q [$];

    // expectations of the operation in flight
    logic   exp_store;
    addr_t  exp_base;
    vaddr_t exp_vd;
    vmsk_t  exp_mask;
    vreg_t  exp_load, exp_merge, exp_wdata;

    lsu_top i_lsu_top (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    //////////////////////////////////////////////////
    // reference and checks
    //////////////////////////////////////////////////

    // byte rule: vl elements of 1, 2 or 4 bytes, at most one register
    function automatic void expected_bytes(input vl_t vl, input eew_e eew, input vreg_t src,
                                           input vreg_t old, output vreg_t merged,
                                           output vmsk_t mask);
        int nbytes;
        case (eew)
            EEW_16:  nbytes = 2 * int'(vl);
            EEW_32:  nbytes = 4 * int'(vl);
            default: nbytes = int'(vl);
        endcase
        nbytes = (nbytes > 16) ? 16 : nbytes;
        merged = old;
        for (int i = 0; i < 16; i++) begin
            mask[i] = (i < nbytes);
            if (i < nbytes) begin
                merged[8*i +: 8] = src[8*i +: 8];
            end
        end
    endfunction

    function automatic vreg_t read_block(addr_t base);
        vreg_t blk;
        addr_t a;
        for (int i = 0; i < 16; i++) begin
            a = base + addr_t'(i);
            blk[8*i +: 8] = mem[a[9:0]];
        end
        return blk;
    endfunction

    task automatic stop_run(string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_vreg(string name, vreg_t got, vreg_t exp);
        if (got !== exp) begin
            stop_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_mask(string name, vmsk_t got, vmsk_t exp);
        if (got !== exp) begin
            stop_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_be(string name, be_t got, be_t exp);
        if (got !== exp) begin
            stop_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_addr(string name, addr_t got, addr_t exp);
        if (got !== exp) begin
            stop_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_word(string name, vmem_t got, vmem_t exp);
        if (got !== exp) begin
            stop_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_vaddr(string name, vaddr_t got, vaddr_t exp);
        if (got !== exp) begin
            stop_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            stop_run($sformatf("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            stop_run("timeout, the unit did not finish its operations in time");
        end
    end

    //////////////////////////////////////////////////
    // memory model
    //////////////////////////////////////////////////

    always @(posedge clk_i) begin
        int    due;
        addr_t a;
        vmem_t word;
        data_gnt_i <= ($random(seed) & 3) != 0;
        if (async_rst_ni && data_req_o && data_gnt_i) begin
            for (int b = 0; b < 4; b++) begin
                a = data_addr_o + addr_t'(b);
                if (data_we_o && data_be_o[b]) begin
                    mem[a[9:0]] = data_wdata_o[8*b +: 8];
                end
                word[8*b +: 8] = mem[a[9:0]];
            end
            if (!data_we_o) begin
                // in-order return after 1 to 3 cycles
                due = cycles + 1 + int'($unsigned($random(seed)) % 3);
                due = (due > last_due) ? due : last_due + 1;
                last_due = due;
                rdata_q.push_back(word);
                due_q.push_back(due);
            end
        end
        if (due_q.size() > 0 && due_q[0] <= cycles) begin
            data_rvalid_i <= 1'b1;
            data_rdata_i  <= rdata_q.pop_front();
            void'(due_q.pop_front());
        end else begin
            data_rvalid_i <= 1'b0;
        end
    end

    // compare granted beats and register writes with the reference
    always @(posedge clk_i) begin
        if (async_rst_ni && data_req_o && data_gnt_i) begin
            check_flag("data_we_o", data_we_o, exp_store);
            check_addr("data_addr_o", data_addr_o, exp_base + addr_t'(4 * beat_seen));
            check_be("data_be_o", data_be_o, exp_store ? exp_mask[4*beat_seen +: 4] : be_t'('1));
            if (exp_store) begin
                check_word("data_wdata_o", data_wdata_o, exp_wdata[32*beat_seen +: 32]);
            end
            beat_seen++;
        end
        if (async_rst_ni && vreg_wr_en_o) begin
            if (exp_store) begin
                stop_run("register write during a store");
            end
            check_vaddr("vreg_wr_addr_o", vreg_wr_addr_o, exp_vd);
            check_vreg("vreg_wr_data_o", vreg_wr_data_o, exp_load);
            check_mask("vreg_wr_mask_o", vreg_wr_mask_o, exp_mask);
            rf[exp_vd] = exp_merge;
            wr_seen++;
        end
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    // issue one operation, then wait for op_ready_o to come back
    task automatic run_op(logic store, eew_e eew, vl_t vl, addr_t base, vaddr_t vd);
        vreg_t blk;
        vreg_t merged;
        vmsk_t mask;
        op_valid_i     <= 1'b1;
        op_store_i     <= store;
        op_eew_i       <= eew;
        op_vl_i        <= vl;
        op_base_i      <= base;
        op_vd_i        <= vd;
        vreg_rd_data_i <= rf[vd];
        @(posedge clk_i);
        while (!op_ready_o) begin
            @(posedge clk_i);
        end
        // acceptance edge
        check_flag("misaligned_o", misaligned_o, base[1:0] != 2'b00);
        check_vaddr("vreg_rd_addr_o", vreg_rd_addr_o, vd);
        exp_store = store;
        exp_base  = {base[31:2], 2'b00};
        exp_vd    = vd;
        exp_wdata = rf[vd];
        beat_seen = 0;
        wr_seen   = 0;
        blk       = read_block(exp_base);
        if (store) begin
            expected_bytes(vl, eew, rf[vd], blk, merged, mask);
        end else begin
            expected_bytes(vl, eew, blk, rf[vd], merged, mask);
            exp_load = blk;
        end
        exp_mask   = mask;
        exp_merge  = merged;
        op_valid_i <= 1'b0;
        @(posedge clk_i);
        while (!op_ready_o) begin
            if (store ? !pending_store_o : !pending_load_o) begin
                stop_run("pending status dropped before the operation finished");
            end
            @(posedge clk_i);
        end
        if (beat_seen != 4 || wr_seen != (store ? 0 : 1)) begin
            stop_run("operation did not issue four beats and the expected register writes");
        end
        if (store) begin
            check_vreg("memory block", read_block(exp_base), merged);
        end
    endtask

    initial begin
        logic   store;
        eew_e   eew;
        vl_t    vl;
        addr_t  base;
        vaddr_t vd;
        async_rst_ni   = 1'b0;
        op_valid_i     = 1'b0;
        op_store_i     = 1'b0;
        op_eew_i       = EEW_8;
        op_vl_i        = '0;
        op_base_i      = '0;
        op_vd_i        = '0;
        vreg_rd_data_i = '0;
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 8'((i * 13) ^ (i >> 3));
        end
        for (int r = 0; r < 32; r++) begin
            rf[r] = {$random(seed), $random(seed), $random(seed), $random(seed)};
        end
        repeat (4) @(posedge clk_i);
        async_rst_ni <= 1'b1;
        @(posedge clk_i);
        check_flag("op_ready_o", op_ready_o, 1'b1);
        check_flag("data_req_o", data_req_o, 1'b0);
        check_flag("vreg_wr_en_o", vreg_wr_en_o, 1'b0);
        check_flag("pending_load_o", pending_load_o, 1'b0);
        check_flag("pending_store_o", pending_store_o, 1'b0);
        // stores, one with vl of zero
        run_op(1'b1, EEW_8,  5'd16, 32'h0000_0100, 5'd1);
        run_op(1'b1, EEW_8,  5'd0,  32'h0000_0140, 5'd2);
        run_op(1'b1, EEW_16, 5'd5,  32'h0000_0180, 5'd3);
        run_op(1'b1, EEW_32, 5'd3,  32'h0000_01c0, 5'd4);
        // loads for each element width, the last one past a full register
        run_op(1'b0, EEW_8,  5'd7,  32'h0000_0100, 5'd5);
        run_op(1'b0, EEW_16, 5'd6,  32'h0000_0200, 5'd6);
        run_op(1'b0, EEW_32, 5'd4,  32'h0000_0240, 5'd7);
        run_op(1'b0, EEW_32, 5'd9,  32'h0000_0280, 5'd8);
        // misaligned bases
        run_op(1'b0, EEW_16, 5'd8,  32'h0000_0303, 5'd9);
        run_op(1'b1, EEW_8,  5'd11, 32'h0000_0311, 5'd10);
        for (int n = 0; n < 30; n++) begin
            store = 1'($random(seed));
            eew   = eew_e'(2'($unsigned($random(seed)) % 3));
            vl    = vl_t'($unsigned($random(seed)) % 17);
            base  = addr_t'($random(seed));
            vd    = vaddr_t'($random(seed));
            run_op(store, eew, vl, base, vd);
        end
        repeat (2) @(posedge clk_i);
        $display("TEST PASSED");
        $finish;
    end

endmodule
